// ==== list.f ====
+incdir+common
common/ps_sys_pkg.sv
regmap/ps_reg_slave.sv
design/ps_sys_ctrl.sv
dac/dac_sample_fifo.sv
dac/dac_batcher.sv
design/ps_sys_top.sv
tests/ps_sys_properties.sv
tests/ps_sys_tb.sv

// ==== Bender.yml ====
package:
  name: ps_sys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ps_sys_pkg.sv
      - regmap/ps_reg_slave.sv
      - design/ps_sys_ctrl.sv
      - dac/dac_sample_fifo.sv
      - dac/dac_batcher.sv
      - design/ps_sys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/ps_sys_properties.sv
      - tests/ps_sys_tb.sv

// ==== tests/ps_sys_tb.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module ps_sys_tb import ps_sys_pkg::*; ();
    localparam int CLK_PERIOD = 20;
    localparam int HS_LIMIT   = 40; // Cycles any handshake may take
    localparam int AW = `REG_ADDR_WIDTH;
    localparam int DW = `REG_DATA_WIDTH;
    localparam int SW = `SAMPLE_WIDTH;
    // Cycle budgets of the six tests, in order
    localparam int TEST_CYCLES = 100 + 150 + 150 + 250 + 200 + 150;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic ps_clk;
    logic ps_rst;
    logic wr_valid;
    logic [AW:0] wr_addr;
    logic [DW-1:0] wr_data;
    logic wr_ready;
    logic b_valid;
    logic b_err;
    logic b_ready;
    logic rd_valid;
    logic [AW:0] rd_addr;
    logic rd_ready;
    logic r_valid;
    logic [DW-1:0] r_data;
    logic r_err;
    logic r_ready;
    logic dac_rdy;
    logic [`BATCH_SAMPLES-1:0][SW-1:0] dac_batch;
    logic valid_dac_batch;
    logic pl_rstn;

    int errors = 0;
    int checks = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int failed_tests = 0;
    int rstn_low_cycles = 0;
    int exp_scale = 0; // Copies of the written scale and burst
    int exp_burst = 0;
    bit batch_forbidden = 0;
    logic [31:0] rng_state = 32'd54;
    logic [SW-1:0] model_q[$]; // Samples in the FIFO, oldest first

    ps_sys_top dut (.*);

    bind ps_sys_top ps_sys_properties u_props (
        .ps_clk(ps_clk), .rst(rst), .wr_ready(wr_ready),
        .b_valid(b_valid), .b_err(b_err), .b_ready(b_ready),
        .rd_ready(rd_ready), .r_valid(r_valid), .r_data(r_data), .r_err(r_err),
        .r_ready(r_ready), .sample_push(sample_push), .fifo_level(fifo_level)
    );

    always #(CLK_PERIOD / 2) ps_clk = ~ps_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge ps_clk);
        #2; // Inputs change just after the edge
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic require(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("[ERROR] %0t ns: %s", $time, what);
        end
    endtask

    task automatic write_reg(input logic [AW:0] addr, input logic [DW-1:0] data,
                             output logic err);
        bit done;
        int cnt;
        done = 0;
        cnt = 0;
        err = 1'b1;
        wr_valid = 1'b1;
        wr_addr = addr;
        wr_data = data;
        while (!done && cnt < HS_LIMIT) begin
            @(negedge ps_clk);
            done = wr_ready;
            next_cycle();
            cnt++;
        end
        wr_valid = 1'b0;
        require(done, $sformatf("write to address %0d was never accepted", addr));
        if (!done) return;
        next_cycle(); // Host takes the response one cycle late
        b_ready = 1'b1;
        done = 0;
        cnt = 0;
        while (!done && cnt < HS_LIMIT) begin
            @(negedge ps_clk);
            done = b_valid;
            err = b_err;
            next_cycle();
            cnt++;
        end
        b_ready = 1'b0;
        require(done, "write response never arrived");
    endtask

    task automatic read_reg(input logic [AW:0] addr, output logic [DW-1:0] data,
                            output logic err);
        bit done;
        int cnt;
        done = 0;
        cnt = 0;
        err = 1'b1;
        data = '0;
        rd_valid = 1'b1;
        rd_addr = addr;
        while (!done && cnt < HS_LIMIT) begin
            @(negedge ps_clk);
            done = rd_ready;
            next_cycle();
            cnt++;
        end
        rd_valid = 1'b0;
        require(done, $sformatf("read of address %0d was never accepted", addr));
        if (!done) return;
        next_cycle(); // Host takes the response one cycle late
        r_ready = 1'b1;
        done = 0;
        cnt = 0;
        while (!done && cnt < HS_LIMIT) begin
            @(negedge ps_clk);
            done = r_valid;
            data = r_data;
            err = r_err;
            next_cycle();
            cnt++;
        end
        r_ready = 1'b0;
        require(done, "read response never arrived");
    endtask

    task automatic write_expect_ok(input logic [AW:0] addr, input logic [DW-1:0] data);
        logic err;
        write_reg(addr, data, err);
        check_equal($sformatf("b_err of write to %0d", addr), err, 0);
    endtask

    task automatic expect_read(input logic [AW:0] addr, input logic [DW-1:0] exp,
                               input string what);
        logic [DW-1:0] data;
        logic err;
        read_reg(addr, data, err);
        check_equal(what, data, exp);
        check_equal($sformatf("r_err of read from %0d", addr), err, 0);
    endtask

    task automatic push_sample();
        rng_state = xorshift32(rng_state);
        write_expect_ok(REG_SAMPLE, rng_state[SW-1:0]);
        model_q.push_back(rng_state[SW-1:0]);
    endtask

    // Next batch must hold the four oldest model samples, scaled
    task automatic expect_batch();
        logic [SW-1:0] sample;
        logic [SW-1:0] expected;
        bit seen;
        int cnt;
        seen = 0;
        cnt = 0;
        while (!seen && cnt < HS_LIMIT) begin
            @(negedge ps_clk);
            seen = valid_dac_batch;
            if (seen) begin
                for (int k = 0; k < `BATCH_SAMPLES; k++) begin
                    sample = model_q.pop_front();
                    // Copies of the sign bit fill in from the top
                    expected = SW'({{SW{sample[SW-1]}}, sample} >> exp_scale);
                    check_equal($sformatf("dac_batch[%0d]", k), dac_batch[k], expected);
                end
            end
            next_cycle();
            cnt++;
        end
        require(seen, "valid_dac_batch never rose for an expected batch");
    endtask

    task automatic expect_write_stall(input logic [AW:0] addr, input logic [DW-1:0] data,
                                      input int cycles, input string what);
        wr_valid = 1'b1;
        wr_addr = addr;
        wr_data = data;
        repeat (cycles) begin
            @(negedge ps_clk);
            require(!wr_ready, {"write to ", what, " was accepted while it should stall"});
            next_cycle();
        end
        wr_valid = 1'b0; // Withdrawn unaccepted
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_at_start;
        if (n != 0) failed_tests++;
        tests_run++;
        $display("Test %0d %s: %s (%0d errors)", tests_run, name, (n == 0) ? "ok" : "failed", n);
        errors_at_start = errors;
    endtask

    always @(negedge ps_clk) begin
        if (!pl_rstn) rstn_low_cycles++;
        if (batch_forbidden) begin
            require(!valid_dac_batch, "valid_dac_batch rose while no batch may be emitted");
        end
    end

    initial begin
        logic err;
        logic [DW-1:0] rdata;
        int n;
        int prop_fails;
        ps_clk = 1'b0;
        ps_rst = 1'b1;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        b_ready = 1'b0;
        rd_valid = 1'b0;
        rd_addr = '0;
        r_ready = 1'b0;
        dac_rdy = 1'b1;
        repeat (8) @(posedge ps_clk);
        #2;
        ps_rst = 1'b0;

        @(negedge ps_clk);
        check_equal("pl_rstn", pl_rstn, 0); // Still low one cycle past ps_rst
        next_cycle();
        @(negedge ps_clk);
        check_equal("pl_rstn", pl_rstn, 1);
        next_cycle();
        exp_scale = 5;
        exp_burst = 3;
        write_expect_ok(REG_SCALE, exp_scale);
        write_expect_ok(REG_BURST, exp_burst);
        expect_read(REG_SCALE, exp_scale, "REG_SCALE");
        expect_read(REG_BURST, exp_burst, "REG_BURST");
        write_reg(REG_BATCH_CNT, 16'h1234, err);
        check_equal("b_err", err, 1);
        expect_read(REG_BATCH_CNT, 0, "REG_BATCH_CNT");
        read_reg((AW + 1)'(`REG_COUNT + 1), rdata, err);
        check_equal("r_err", err, 1);
        end_test("register access");

        repeat (8) push_sample();
        exp_scale = 2;
        exp_burst = 2;
        write_expect_ok(REG_SCALE, exp_scale);
        write_expect_ok(REG_BURST, exp_burst);
        write_expect_ok(REG_TRIG, 1);
        repeat (exp_burst) expect_batch();
        repeat (4) next_cycle(); // Count and status write-back lag
        expect_read(REG_BATCH_CNT, exp_burst, "REG_BATCH_CNT");
        end_test("batch content");

        dac_rdy = 1'b0;
        batch_forbidden = 1;
        repeat (4) push_sample();
        exp_burst = 1;
        write_expect_ok(REG_BURST, exp_burst);
        write_expect_ok(REG_TRIG, 1);
        expect_write_stall(REG_TRIG, 1, 12, "REG_TRIG");
        batch_forbidden = 0;
        dac_rdy = 1'b1;
        expect_batch();
        end_test("back-pressure and trigger stall");

        repeat (`FIFO_DEPTH) push_sample();
        repeat (3) next_cycle();
        expect_read(REG_FIFO_LVL, `FIFO_DEPTH, "REG_FIFO_LVL");
        expect_write_stall(REG_SAMPLE, 16'h0bad, 8, "REG_SAMPLE");
        write_expect_ok(REG_TRIG, 1); // Burst of one frees a batch
        expect_batch();
        push_sample();
        repeat (3) next_cycle();
        expect_read(REG_FIFO_LVL, model_q.size(), "REG_FIFO_LVL");
        end_test("FIFO full");

        exp_burst = 8;
        write_expect_ok(REG_BURST, exp_burst);
        write_expect_ok(REG_TRIG, 1);
        n = model_q.size() / `BATCH_SAMPLES; // Batches the FIFO can feed
        repeat (n) expect_batch();
        write_expect_ok(REG_HALT, 1);
        batch_forbidden = 1;
        repeat (`BATCH_SAMPLES) push_sample();
        repeat (10) next_cycle();
        batch_forbidden = 0;
        expect_read(REG_BATCH_CNT, n, "REG_BATCH_CNT");
        expect_read(REG_FIFO_LVL, model_q.size(), "REG_FIFO_LVL");
        end_test("halt");

        rstn_low_cycles = 0;
        write_expect_ok(REG_RST, 1);
        check_equal("pl_rstn low cycles", rstn_low_cycles, 0); // None before the response
        repeat (8) next_cycle();
        check_equal("pl_rstn low cycles", rstn_low_cycles, 1);
        model_q.delete();
        exp_scale = 0;
        exp_burst = 0;
        for (int a = 0; a < `REG_COUNT; a++) begin
            expect_read(a, 0, $sformatf("register %0d", a));
        end
        end_test("reset command");

        prop_fails = dut.u_props.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d property failures",
                 tests_run, failed_tests, checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("[ERROR] %0t ns: watchdog expired before the tests finished", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== tests/ps_sys_properties.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module ps_sys_properties (
    input logic ps_clk,
    input logic rst,
    input logic wr_ready,
    input logic b_valid,
    input logic b_err,
    input logic b_ready,
    input logic rd_ready,
    input logic r_valid,
    input logic [`REG_DATA_WIDTH-1:0] r_data,
    input logic r_err,
    input logic r_ready,
    input logic sample_push,
    input logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level
);
    int fail_count = 0; // Read by the testbench at the end of the run

    wr_stall_on_resp: assert property (@(posedge ps_clk) disable iff (rst)
        b_valid |-> !wr_ready)
        else begin
            fail_count++;
            $error("wr_ready high while a write response is pending");
        end

    b_hold: assert property (@(posedge ps_clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b_err))
        else begin
            fail_count++;
            $error("write response dropped or changed before b_ready");
        end

    r_hold: assert property (@(posedge ps_clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_err))
        else begin
            fail_count++;
            $error("read response dropped or changed before r_ready");
        end

    rd_stall_on_resp: assert property (@(posedge ps_clk) disable iff (rst)
        r_valid |-> !rd_ready)
        else begin
            fail_count++;
            $error("rd_ready high while a read response is pending");
        end

    no_push_when_full: assert property (@(posedge ps_clk) disable iff (rst)
        sample_push |-> fifo_level < `FIFO_DEPTH)
        else begin
            fail_count++;
            $error("sample pushed into a full FIFO");
        end

    // A short pop wraps the level past empty
    level_in_range: assert property (@(posedge ps_clk) disable iff (rst)
        fifo_level <= `FIFO_DEPTH)
        else begin
            fail_count++;
            $error("FIFO level wrapped, a batch was popped short or the FIFO overflowed");
        end

endmodule

// ==== design/ps_sys_top.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module ps_sys_top (
    input  logic ps_clk,
    input  logic ps_rst,
    // Host bus
    input  logic wr_valid,
    input  logic [`REG_ADDR_WIDTH:0] wr_addr,
    input  logic [`REG_DATA_WIDTH-1:0] wr_data,
    output logic wr_ready,
    output logic b_valid,
    output logic b_err,
    input  logic b_ready,
    input  logic rd_valid,
    input  logic [`REG_ADDR_WIDTH:0] rd_addr,
    output logic rd_ready,
    output logic r_valid,
    output logic [`REG_DATA_WIDTH-1:0] r_data,
    output logic r_err,
    input  logic r_ready,
    // DAC port
    input  logic dac_rdy,
    output logic [`BATCH_SAMPLES-1:0][`SAMPLE_WIDTH-1:0] dac_batch,
    output logic valid_dac_batch,
    output logic pl_rstn
);
    logic rst;
    logic rst_cmd;
    logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] regs;
    logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] rtl_wr_data;
    logic [`REG_COUNT-1:0] fresh;
    logic [`REG_COUNT-1:0] owner_rdy;
    logic [`REG_COUNT-1:0] rtl_wr_req;
    logic sample_push;
    logic [`SAMPLE_WIDTH-1:0] sample_data;
    logic [$clog2(`SAMPLE_WIDTH)-1:0] scale_factor;
    logic [$clog2(`MAX_DAC_BURST_SIZE + 1)-1:0] burst_size;
    logic trig_pulse;
    logic halt_pulse;
    logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level;
    logic [`BATCH_SAMPLES-1:0][`SAMPLE_WIDTH-1:0] head_batch;
    logic pop;
    logic batch_done;
    logic burst_busy;

    assign rst     = ps_rst || rst_cmd; // Register command resets everything
    assign pl_rstn = ~rst_cmd;

    ps_reg_slave u_slave (
        .ps_clk(ps_clk), .rst(rst),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ready(wr_ready),
        .b_valid(b_valid), .b_err(b_err), .b_ready(b_ready),
        .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready),
        .r_valid(r_valid), .r_data(r_data), .r_err(r_err), .r_ready(r_ready),
        .owner_rdy(owner_rdy), .rtl_wr_req(rtl_wr_req), .rtl_wr_data(rtl_wr_data),
        .regs(regs), .fresh(fresh)
    );

    ps_sys_ctrl u_ctrl (
        .ps_clk(ps_clk), .ps_rst(ps_rst),
        .fresh(fresh), .regs(regs), .fifo_level(fifo_level),
        .batch_done(batch_done), .burst_busy(burst_busy),
        .rst_cmd(rst_cmd), .owner_rdy(owner_rdy),
        .rtl_wr_req(rtl_wr_req), .rtl_wr_data(rtl_wr_data),
        .sample_push(sample_push), .sample_data(sample_data),
        .scale_factor(scale_factor), .burst_size(burst_size),
        .trig_pulse(trig_pulse), .halt_pulse(halt_pulse)
    );

    dac_sample_fifo u_fifo (
        .ps_clk(ps_clk), .rst(rst),
        .push(sample_push), .push_data(sample_data), .pop(pop),
        .fifo_level(fifo_level), .head_batch(head_batch)
    );

    dac_batcher u_batcher (
        .ps_clk(ps_clk), .rst(rst),
        .scale_factor(scale_factor), .burst_size(burst_size),
        .trig_pulse(trig_pulse), .halt_pulse(halt_pulse),
        .fifo_level(fifo_level), .head_batch(head_batch), .dac_rdy(dac_rdy),
        .pop(pop), .batch_done(batch_done), .burst_busy(burst_busy),
        .dac_batch(dac_batch), .valid_dac_batch(valid_dac_batch)
    );

endmodule

// ==== dac/dac_batcher.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module dac_batcher import ps_sys_pkg::*; (
    input  logic ps_clk,
    input  logic rst,
    input  logic [$clog2(`SAMPLE_WIDTH)-1:0] scale_factor,
    input  logic [$clog2(`MAX_DAC_BURST_SIZE + 1)-1:0] burst_size,
    input  logic trig_pulse,
    input  logic halt_pulse,
    input  logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level,
    input  logic [`BATCH_SAMPLES-1:0][`SAMPLE_WIDTH-1:0] head_batch,
    input  logic dac_rdy,
    output logic pop,
    output logic batch_done,
    output logic burst_busy,
    output logic [`BATCH_SAMPLES-1:0][`SAMPLE_WIDTH-1:0] dac_batch,
    output logic valid_dac_batch
);
    localparam int BURST_W = $clog2(`MAX_DAC_BURST_SIZE + 1);

    batch_state_e state;
    logic [BURST_W-1:0] remaining; // Batches left in this burst

    assign burst_busy = state == BATCH_RUN;

    // Halt wins over a batch in the same cycle
    assign pop = burst_busy && !halt_pulse && dac_rdy && (fifo_level >= `BATCH_SAMPLES);

    always_ff @(posedge ps_clk) begin
        if (rst) begin
            state           <= BATCH_IDLE;
            remaining       <= '0;
            valid_dac_batch <= 1'b0;
            batch_done      <= 1'b0;
        end else begin
            valid_dac_batch <= 1'b0;
            batch_done      <= 1'b0;
            case (state)
                BATCH_IDLE: begin
                    if (trig_pulse && (burst_size != '0)) begin
                        remaining <= burst_size;
                        state     <= BATCH_RUN;
                    end
                end
                BATCH_RUN: begin
                    if (halt_pulse) begin
                        remaining <= '0;
                        state     <= BATCH_IDLE;
                    end else if (pop) begin
                        remaining       <= remaining - 1'b1;
                        valid_dac_batch <= 1'b1;
                        batch_done      <= 1'b1;
                        if (remaining == BURST_W'(1)) state <= BATCH_IDLE; // Last batch
                    end
                end
                default: state <= BATCH_IDLE;
            endcase
        end
    end

    // Scaled batch, arithmetic shift keeps the sign
    always_ff @(posedge ps_clk) begin
        if (pop) begin
            for (int k = 0; k < `BATCH_SAMPLES; k++) begin
                dac_batch[k] <= $signed(head_batch[k]) >>> scale_factor;
            end
        end
    end

endmodule

// ==== dac/dac_sample_fifo.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module dac_sample_fifo (
    input  logic ps_clk,
    input  logic rst,
    input  logic push,
    input  logic [`SAMPLE_WIDTH-1:0] push_data,
    input  logic pop, // Removes a whole batch
    output logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level,
    output logic [`BATCH_SAMPLES-1:0][`SAMPLE_WIDTH-1:0] head_batch
);
    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int LVL_W = $clog2(`FIFO_DEPTH + 1);

    logic [`SAMPLE_WIDTH-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Oldest entries, wrapping around the buffer
    for (genvar k = 0; k < `BATCH_SAMPLES; k++) begin : g_head
        assign head_batch[k] = mem[rd_ptr + PTR_W'(k)];
    end

    always_ff @(posedge ps_clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge ps_clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_level <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + PTR_W'(`BATCH_SAMPLES);
            case ({push, pop})
                2'b10: fifo_level <= fifo_level + 1'b1;
                2'b01: fifo_level <= fifo_level - LVL_W'(`BATCH_SAMPLES);
                2'b11: fifo_level <= fifo_level + 1'b1 - LVL_W'(`BATCH_SAMPLES);
                default: ;
            endcase
        end
    end

endmodule

// ==== design/ps_sys_ctrl.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module ps_sys_ctrl import ps_sys_pkg::*; (
    input  logic ps_clk,
    input  logic ps_rst,
    input  logic [`REG_COUNT-1:0] fresh,
    input  logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] regs,
    input  logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level,
    input  logic batch_done,
    input  logic burst_busy,
    output logic rst_cmd,
    output logic [`REG_COUNT-1:0] owner_rdy,
    output logic [`REG_COUNT-1:0] rtl_wr_req,
    output logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] rtl_wr_data,
    output logic sample_push,
    output logic [`SAMPLE_WIDTH-1:0] sample_data,
    output logic [$clog2(`SAMPLE_WIDTH)-1:0] scale_factor,
    output logic [$clog2(`MAX_DAC_BURST_SIZE + 1)-1:0] burst_size,
    output logic trig_pulse,
    output logic halt_pulse
);
    localparam int LVL_W   = $clog2(`FIFO_DEPTH + 1);
    localparam int SCALE_W = $clog2(`SAMPLE_WIDTH);
    localparam int BURST_W = $clog2(`MAX_DAC_BURST_SIZE + 1);

    ctrl_rst_state_e rst_state;
    logic ctrl_rst;
    logic [`REG_DATA_WIDTH-1:0] batch_cnt;

    assign ctrl_rst = ps_rst || rst_cmd;

    // Samples go straight into the FIFO
    assign sample_push = fresh[REG_SAMPLE];
    assign sample_data = regs[REG_SAMPLE][`SAMPLE_WIDTH-1:0];

    always_comb begin
        owner_rdy = '1;
        owner_rdy[REG_RST]    = rst_state == RST_IDLE;
        owner_rdy[REG_SAMPLE] = fifo_level < LVL_W'(`FIFO_DEPTH); // Stall when full
        owner_rdy[REG_TRIG]   = !burst_busy && !trig_pulse;
    end

    // Status registers are refreshed every cycle
    always_comb begin
        rtl_wr_req  = '0;
        rtl_wr_data = '0;
        rtl_wr_req[REG_BATCH_CNT]  = 1'b1;
        rtl_wr_data[REG_BATCH_CNT] = batch_cnt;
        rtl_wr_req[REG_FIFO_LVL]   = 1'b1;
        rtl_wr_data[REG_FIFO_LVL]  = `REG_DATA_WIDTH'(fifo_level);
    end

    always_ff @(posedge ps_clk) begin
        if (ctrl_rst) begin
            rst_cmd      <= ps_rst; // Holds pl_rstn low one cycle past ps_rst
            rst_state    <= RST_IDLE;
            scale_factor <= '0;
            burst_size   <= '0;
            trig_pulse   <= 1'b0;
            halt_pulse   <= 1'b0;
            batch_cnt    <= '0;
        end else begin
            case (rst_state)
                RST_IDLE: begin
                    if (fresh[REG_RST]) rst_state <= RST_PULSE;
                end
                RST_PULSE: begin
                    rst_cmd   <= 1'b1; // Next cycle resets the whole system
                    rst_state <= RST_IDLE;
                end
                default: rst_state <= RST_IDLE;
            endcase

            if (fresh[REG_SCALE]) scale_factor <= regs[REG_SCALE][SCALE_W-1:0];
            if (fresh[REG_BURST]) begin
                if (regs[REG_BURST] > `MAX_DAC_BURST_SIZE) begin
                    burst_size <= BURST_W'(`MAX_DAC_BURST_SIZE);
                end else begin
                    burst_size <= regs[REG_BURST][BURST_W-1:0];
                end
            end

            trig_pulse <= fresh[REG_TRIG];
            halt_pulse <= fresh[REG_HALT];

            if (trig_pulse) batch_cnt <= '0; // New burst counts from zero
            else if (batch_done) batch_cnt <= batch_cnt + 1'b1;
        end
    end

endmodule

// ==== regmap/ps_reg_slave.sv ====
`timescale 1ns/100ps
`include "ps_sys_config.svh"

module ps_reg_slave import ps_sys_pkg::*; (
    input  logic ps_clk,
    input  logic rst,
    // Write request and response
    input  logic wr_valid,
    input  logic [`REG_ADDR_WIDTH:0] wr_addr, // Top half lies outside the map
    input  logic [`REG_DATA_WIDTH-1:0] wr_data,
    output logic wr_ready,
    output logic b_valid,
    output logic b_err,
    input  logic b_ready,
    // Read request and response
    input  logic rd_valid,
    input  logic [`REG_ADDR_WIDTH:0] rd_addr,
    output logic rd_ready,
    output logic r_valid,
    output logic [`REG_DATA_WIDTH-1:0] r_data,
    output logic r_err,
    input  logic r_ready,
    // Register side
    input  logic [`REG_COUNT-1:0] owner_rdy,
    input  logic [`REG_COUNT-1:0] rtl_wr_req,
    input  logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] rtl_wr_data,
    output logic [`REG_COUNT-1:0][`REG_DATA_WIDTH-1:0] regs,
    output logic [`REG_COUNT-1:0] fresh
);
    localparam int AW = `REG_ADDR_WIDTH;

    logic [AW-1:0] wr_idx; // Target of the pending response
    logic wr_ok;           // Pending write changed a register
    logic wr_block;        // Gap cycle after a response handshake
    logic wr_in_map;
    logic rd_in_map;
    logic wr_fire;
    logic rd_fire;

    function automatic logic is_read_only(input logic [AW-1:0] idx);
        return (idx == REG_BATCH_CNT) || (idx == REG_FIFO_LVL);
    endfunction

    assign wr_in_map = wr_addr < `REG_COUNT;
    assign rd_in_map = rd_addr < `REG_COUNT;

    // Unmapped targets are always accepted so they can be refused with b_err
    assign wr_ready = !b_valid && !wr_block && (!wr_in_map || owner_rdy[wr_addr[AW-1:0]]);
    assign rd_ready = !r_valid;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge ps_clk) begin
        if (rst) begin
            regs     <= '0;
            fresh    <= '0;
            b_valid  <= 1'b0;
            wr_block <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            fresh    <= '0;
            wr_block <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (rtl_wr_req[i] && is_read_only(AW'(i))) begin
                    regs[i] <= rtl_wr_data[i]; // Status write-back, never fresh
                end
            end
            if (wr_fire) begin
                b_valid <= 1'b1;
                if (wr_in_map && !is_read_only(wr_addr[AW-1:0])) begin
                    regs[wr_addr[AW-1:0]] <= wr_data;
                end
            end else if (b_valid && b_ready) begin
                b_valid  <= 1'b0;
                wr_block <= 1'b1;
                if (wr_ok) begin
                    fresh[wr_idx] <= 1'b1; // Owner sees it after the response
                end
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge ps_clk) begin
        if (wr_fire) begin
            wr_idx <= wr_addr[AW-1:0];
            wr_ok  <= wr_in_map && !is_read_only(wr_addr[AW-1:0]);
            b_err  <= !wr_in_map || is_read_only(wr_addr[AW-1:0]);
        end
        if (rd_fire) begin
            r_err  <= !rd_in_map;
            r_data <= rd_in_map ? regs[rd_addr[AW-1:0]] : '0;
        end
    end

endmodule

// ==== common/ps_sys_pkg.sv ====
`include "ps_sys_config.svh"

package ps_sys_pkg;

    // Register ids, equal to their word address
    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        REG_RST       = 0,
        REG_HALT      = 1,
        REG_BURST     = 2,
        REG_SCALE     = 3,
        REG_SAMPLE    = 4,
        REG_TRIG      = 5,
        REG_BATCH_CNT = 6, // Read-only
        REG_FIFO_LVL  = 7  // Read-only
    } reg_id_e;

    typedef enum logic {
        RST_IDLE,
        RST_PULSE
    } ctrl_rst_state_e;

    typedef enum logic {
        BATCH_IDLE,
        BATCH_RUN
    } batch_state_e;

endpackage

// ==== common/ps_sys_config.svh ====
`ifndef PS_SYS_CONFIG_SVH
`define PS_SYS_CONFIG_SVH

// Register map
`define REG_COUNT 8
`define REG_ADDR_WIDTH 3 // Word address inside the map
`define REG_DATA_WIDTH 16

// DAC sample path
`define SAMPLE_WIDTH 16 // Signed samples
`define BATCH_SAMPLES 4 // Samples per DAC beat
`define FIFO_DEPTH 16 // Power of two
`define MAX_DAC_BURST_SIZE 15

`endif
